//--- rtl/div_pkg.sv
`default_nettype none

package div_pkg;

	// ####################################################################
	// widths
	// ####################################################################
	localparam int data_w = 32;       // operand and result width
	localparam int rem_w  = 35;       // partial remainder, three guard bits
	localparam int tag_w  = 4;

	localparam int n_iter = 16;       // two quotient bits per advance

	// ####################################################################
	// result queue
	// ####################################################################
	localparam int fifo_depth = 4;
	localparam int fifo_cnt_w = 3;    // holds 0 .. fifo_depth
	localparam logic [fifo_cnt_w-1:0] fifo_slots = fifo_cnt_w'(fifo_depth);

	// sequencer state encoding
	localparam logic [1:0] seq_idle = 2'd0;
	localparam logic [1:0] seq_run  = 2'd1;   // init cycle, then advances
	localparam logic [1:0] seq_last = 2'd2;   // sign fixup cycle

	typedef struct packed {
		logic [data_w-1:0] quot;
		logic [data_w-1:0] remd;
		logic [tag_w-1:0]  tag;
	} div_result_t;

endpackage

`default_nettype wire

//--- rtl/div_result_if.sv
`timescale 1ns/1ps
`default_nettype none

// finished divide on its way into the result queue
// push is a single-cycle strobe, data valid in the same cycle
interface div_result_if;

	logic                       push;   // from the sequencer
	logic [div_pkg::data_w-1:0] quot;   // from the divider
	logic [div_pkg::data_w-1:0] remd;   // from the divider
	logic [div_pkg::tag_w-1:0]  tag;    // from the sequencer

	div_pkg::div_result_t data;         // record view for the queue

	assign data = '{quot: quot, remd: remd, tag: tag};

	// split source, divider and sequencer each drive their own part
	modport source (output push, quot, remd, tag);

	modport sink (input push, data);

endinterface

`default_nettype wire

//--- rtl/csa35.sv
`timescale 1ns/1ps
`default_nettype none

// one row of full adders with no carry chain
// the caller shifts cout left one place before the final add
module csa35 (
	input  wire  [div_pkg::rem_w-1:0] ain,
	input  wire  [div_pkg::rem_w-1:0] bin,
	input  wire  [div_pkg::rem_w-1:0] cin,
	output logic [div_pkg::rem_w-1:0] sout,
	output logic [div_pkg::rem_w-1:0] cout
);

	// ####################################################################
	// sum and majority per bit position
	// ####################################################################

	assign sout = ain ^ bin ^ cin;

	// carry out of each column, weight is one bit higher
	assign cout = (ain & bin) |
	              (ain & cin) |
	              (bin & cin);

endmodule

`default_nettype wire

//--- rtl/long_div.sv
`timescale 1ns/1ps
`default_nettype none

// radix-4 restoring divider, one init, sixteen advance, one last cycle
// remainder keeps the sign of the dividend, quotient bits are collected
// in the dividend register (inverted when the quotient is negative)
module long_div (
	input  wire                        clk,
	input  wire [div_pkg::data_w-1:0]  dividend,
	input  wire [div_pkg::data_w-1:0]  divisor,
	input  wire                        unsign,
	input  wire                        d_init,
	input  wire                        e_advance,
	input  wire                        e_last,
	div_result_if.source               result
);

	logic                       sign_divisor, sign_dividend;
	logic [div_pkg::data_w-1:0] dvs;
	logic [div_pkg::data_w-1:0] dvd;        // dividend, then quotient
	logic                       sign_dvs, sign_dvd, sign_quot;
	logic [div_pkg::rem_w-1:0]  rem;
	logic                       neg;        // subtract the divisor
	logic [div_pkg::rem_w-1:0]  cin1;
	logic [div_pkg::rem_w-1:0]  base;
	logic [div_pkg::rem_w-1:0]  dvs_x, dvs2_x;
	logic [div_pkg::rem_w-1:0]  sub3_ps, sub3_pc;
	logic [div_pkg::rem_w-1:0]  rem_sub1, rem_sub2, rem_sub3;
	logic [div_pkg::rem_w-1:0]  rem_nxt;
	logic                       bad1, bad2, bad3;
	logic                       quot_1, quot_0;
	logic                       exact;

	assign sign_divisor  = divisor[div_pkg::data_w-1] & ~unsign;
	assign sign_dividend = dividend[div_pkg::data_w-1] & ~unsign;

	always_ff @(posedge clk) begin
		if (d_init) begin
			dvs       <= divisor;
			sign_dvs  <= sign_divisor;
			sign_dvd  <= sign_dividend;
			sign_quot <= sign_dividend ^ sign_divisor;   // from the incoming operands
		end
	end

	// ####################################################################
	// trial subtractions of one, two and three times the divisor
	// ####################################################################

	// signs differ -> add the divisor, otherwise subtract it
	assign neg  = ~sign_quot;
	assign cin1 = {{(div_pkg::rem_w-1){1'b0}}, neg};

	// in the last cycle the remainder itself is tested against the divisor
	assign base = e_last ? rem : {rem[div_pkg::rem_w-3:0], dvd[div_pkg::data_w-1 -: 2]};

	assign dvs_x  = {div_pkg::rem_w{neg}} ^
	                {{(div_pkg::rem_w-div_pkg::data_w){sign_dvs}}, dvs};
	assign dvs2_x = {dvs_x[div_pkg::rem_w-2:0], neg};              // twice, inverted if neg

	assign rem_sub1 = base + dvs_x + cin1;
	assign rem_sub2 = base + dvs2_x + cin1;

	csa35 i_csa (
		.ain  (base),
		.bin  (dvs_x),
		.cin  (dvs2_x),
		.sout (sub3_ps),
		.cout (sub3_pc)
	);

	// two carry-ins for the three-times trial, one rides in the shifted lsb
	assign rem_sub3 = sub3_ps + {sub3_pc[div_pkg::rem_w-2:0], neg} + cin1;

	// a trial is rejected when it flips the remainder away from the dividend sign
	// negative dividends keep the remainder strictly below zero
	assign bad1 = rem_sub1[div_pkg::rem_w-1] ^ sign_dvd;
	assign bad2 = rem_sub2[div_pkg::rem_w-1] ^ sign_dvd;
	assign bad3 = rem_sub3[div_pkg::rem_w-1] ^ sign_dvd;

	assign quot_1 = ~bad2;
	assign quot_0 = (~bad1 & bad2) | ~bad3;

	always_comb begin
		if (!bad3)
			rem_nxt = rem_sub3;
		else if (!bad2)
			rem_nxt = rem_sub2;
		else if (!bad1)
			rem_nxt = rem_sub1;
		else
			rem_nxt = base;     // digit 0, keep the shifted remainder
	end

	// negative dividend whose remainder sits at minus one divisor, division is exact
	assign exact = sign_dvd & (rem_sub1 == '0);

	// ####################################################################
	// state registers, all loaded by d_init
	// ####################################################################

	always_ff @(posedge clk) begin
		if (d_init)
			dvd <= dividend;
		else if (e_advance)
			dvd <= {dvd[div_pkg::data_w-3:0], quot_1 ^ sign_quot, quot_0 ^ sign_quot};
		else if (e_last)
			dvd <= dvd + {{(div_pkg::data_w-1){1'b0}}, sign_quot ^ exact};
	end

	always_ff @(posedge clk) begin
		if (d_init)
			rem <= {div_pkg::rem_w{sign_dividend}};   // -1 for a negative dividend
		else if (e_advance)
			rem <= rem_nxt;
		else if (e_last && exact)
			rem <= '0;
	end

	assign result.quot = dvd;
	assign result.remd = rem[div_pkg::data_w-1:0];

endmodule

`default_nettype wire

//--- rtl/div_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

// request intake and strobe generation for long_div
module div_sequencer (
	input  wire                               clk,
	input  wire                               arst_n,
	input  wire                               start,
	input  wire  [div_pkg::data_w-1:0]        dividend,
	input  wire  [div_pkg::data_w-1:0]        divisor,
	input  wire                               unsign,
	input  wire  [div_pkg::tag_w-1:0]         tag,
	input  wire  [div_pkg::fifo_cnt_w-1:0]    free,
	output logic                              busy,
	output logic [div_pkg::data_w-1:0]        dividend_q,
	output logic [div_pkg::data_w-1:0]        divisor_q,
	output logic                              unsign_q,
	output logic                              d_init,
	output logic                              e_advance,
	output logic                              e_last,
	div_result_if.source                      result
);

	logic [1:0]                state;
	logic [3:0]                cnt;      // advance count
	logic                      push_q;
	logic [div_pkg::tag_w-1:0] tag_q;
	logic                      accept;

	// busy also covers the push cycle and a full queue
	assign busy   = (state != div_pkg::seq_idle) | push_q | (free == '0);
	assign accept = start & ~busy;

	// first run cycle is the init cycle
	assign e_advance = (state == div_pkg::seq_run) & ~d_init;
	assign e_last    = (state == div_pkg::seq_last);

	assign result.push = push_q;
	assign result.tag  = tag_q;

	// ####################################################################
	// control FSM
	// ####################################################################

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state  <= div_pkg::seq_idle;
			cnt    <= '0;
			d_init <= 1'b0;
			push_q <= 1'b0;
		end else begin
			d_init <= accept;
			push_q <= e_last;       // result is final once last is done
			case (state)
				div_pkg::seq_idle: begin
					if (accept) begin
						state <= div_pkg::seq_run;
						cnt   <= '0;
					end
				end
				div_pkg::seq_run: begin
					if (e_advance) begin
						cnt <= cnt + 1'b1;
						if (cnt == 4'(div_pkg::n_iter - 1))
							state <= div_pkg::seq_last;
					end
				end
				default: state <= div_pkg::seq_idle;   // seq_last lasts one cycle
			endcase
		end
	end

	// operands and tag held for the whole divide
	always_ff @(posedge clk) begin
		if (accept) begin
			dividend_q <= dividend;
			divisor_q  <= divisor;
			unsign_q   <= unsign;
			tag_q      <= tag;
		end
	end

endmodule

`default_nettype wire

//--- rtl/result_fifo.sv
`timescale 1ns/1ps
`default_nettype none

// four-entry circular result queue with registered read port
module result_fifo (
	input  wire                             clk,
	input  wire                             arst_n,
	div_result_if.sink                      result,
	input  wire                             rd,
	output logic [div_pkg::fifo_cnt_w-1:0]  free,
	output logic                            not_empty,
	output div_pkg::div_result_t            rd_data
);

	div_pkg::div_result_t mem [div_pkg::fifo_depth];

	logic [$clog2(div_pkg::fifo_depth)-1:0] wr_ptr;
	logic [$clog2(div_pkg::fifo_depth)-1:0] rd_ptr;
	logic [div_pkg::fifo_cnt_w-1:0]         count;
	logic                                   do_wr;
	logic                                   do_rd;

	// the sequencer only starts a divide when a slot is free
	assign do_wr = result.push & (count != div_pkg::fifo_slots);
	assign do_rd = rd & (count != '0);          // read on empty is dropped

	assign free      = div_pkg::fifo_slots - count;
	assign not_empty = (count != '0);

	// ####################################################################
	// storage
	// ####################################################################

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= result.data;
	end

	// ####################################################################
	// pointers and occupancy
	// ####################################################################

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;     // wraps at depth
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;     // none or both
			endcase
		end
	end

	// head entry presented after the read edge, held until the next read
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			rd_data <= '0;
		else if (do_rd)
			rd_data <= mem[rd_ptr];
	end

endmodule

`default_nettype wire

//--- rtl/div_unit.sv
`timescale 1ns/1ps
`default_nettype none

// integer divide unit, sequencer + radix-4 divider + result queue
module div_unit (
	input  wire                        clk,
	input  wire                        arst_n,
	input  wire                        start,
	input  wire  [div_pkg::data_w-1:0] dividend,
	input  wire  [div_pkg::data_w-1:0] divisor,
	input  wire                        unsign,
	input  wire  [div_pkg::tag_w-1:0]  tag,
	output logic                       busy,
	input  wire                        rd,
	output logic                       not_empty,
	output logic [div_pkg::data_w-1:0] rd_quot,
	output logic [div_pkg::data_w-1:0] rd_remd,
	output logic [div_pkg::tag_w-1:0]  rd_tag
);

	logic [div_pkg::data_w-1:0]     dividend_q;
	logic [div_pkg::data_w-1:0]     divisor_q;
	logic                           unsign_q;
	logic                           d_init;
	logic                           e_advance;
	logic                           e_last;
	logic [div_pkg::fifo_cnt_w-1:0] free;
	div_pkg::div_result_t           rd_data;

	div_result_if result_bus ();

	// ####################################################################
	// producer, sequencer and divider
	// ####################################################################

	div_sequencer i_seq (
		.clk        (clk),
		.arst_n     (arst_n),
		.start      (start),
		.dividend   (dividend),
		.divisor    (divisor),
		.unsign     (unsign),
		.tag        (tag),
		.free       (free),
		.busy       (busy),
		.dividend_q (dividend_q),
		.divisor_q  (divisor_q),
		.unsign_q   (unsign_q),
		.d_init     (d_init),
		.e_advance  (e_advance),
		.e_last     (e_last),
		.result     (result_bus.source)    // push and tag
	);

	long_div i_div (
		.clk       (clk),
		.dividend  (dividend_q),
		.divisor   (divisor_q),
		.unsign    (unsign_q),
		.d_init    (d_init),
		.e_advance (e_advance),
		.e_last    (e_last),
		.result    (result_bus.source)     // quot and remd
	);

	// ####################################################################
	// result queue
	// ####################################################################

	result_fifo i_fifo (
		.clk       (clk),
		.arst_n    (arst_n),
		.result    (result_bus.sink),
		.rd        (rd),
		.free      (free),
		.not_empty (not_empty),
		.rd_data   (rd_data)
	);

	assign rd_quot = rd_data.quot;
	assign rd_remd = rd_data.remd;
	assign rd_tag  = rd_data.tag;

endmodule

`default_nettype wire

//--- testbench/div_checker.sv
`timescale 1ns/1ps
`default_nettype none

// watches the divide unit ports and compares read results against
// the expected records queued by the testbench
module div_checker (
	input  wire        clk,
	input  wire        arst_n,
	input  wire        start,
	input  wire        busy,
	input  wire        rd,
	input  wire        not_empty,
	input  wire [31:0] rd_quot,
	input  wire [31:0] rd_remd,
	input  wire [3:0]  rd_tag,
	input  wire        exp_push,     // one expected record per accepted start
	input  wire [31:0] exp_quot,
	input  wire [31:0] exp_remd,
	input  wire [3:0]  exp_tag,
	output int         value_errs,
	output int         other_errs,
	output int         exp_left
);

	div_pkg::div_result_t exp_q [$];
	div_pkg::div_result_t exp_rec;
	div_pkg::div_result_t head;

	logic exp_new = 1'b0;
	logic rd_seen = 1'b0;     // a read hit a non-empty queue
	logic lost    = 1'b0;
	logic ne_prev = 1'b0;
	int   edges   = 0;        // rising edges since the last accepted start
	int   n_value = 0;
	int   n_other = 0;
	int   n_left  = 0;

	assign value_errs = n_value;
	assign other_errs = n_other;
	assign exp_left   = n_left;

	task automatic compare_word(input string name, input logic [31:0] exp, input logic [31:0] got);
		if (got !== exp) begin
			$display("error: %s expected %h got %h", name, exp, got);
			n_value++;
		end
	endtask

	// ####################################################################
	// sample on the rising edge
	// ####################################################################

	always @(posedge clk) begin
		exp_new <= exp_push;
		exp_rec <= '{quot: exp_quot, remd: exp_remd, tag: exp_tag};
		rd_seen <= rd & not_empty;
		lost    <= arst_n & start & busy;
		if (start && !busy)
			edges <= 1;
		else if (edges < 1000)
			edges <= edges + 1;
	end

	// ####################################################################
	// compare on the falling edge, outputs are settled
	// ####################################################################

	always @(negedge clk) begin
		if (!arst_n) begin
			compare_word("busy", 32'd0, 32'(busy));
			compare_word("not_empty", 32'd0, 32'(not_empty));
			compare_word("rd_quot", 32'd0, rd_quot);
			compare_word("rd_remd", 32'd0, rd_remd);
			compare_word("rd_tag", 32'd0, 32'(rd_tag));
		end
		if (exp_new)
			exp_q.push_back(exp_rec);
		if (lost) begin
			$display("start was pulsed while busy was high, the request was lost");
			n_other++;
		end
		if (rd_seen) begin
			if (exp_q.size() == 0) begin
				$display("a read returned a result that was never issued");
				n_other++;
			end else begin
				head = exp_q.pop_front();
				compare_word("rd_quot", head.quot, rd_quot);
				compare_word("rd_remd", head.remd, rd_remd);
				compare_word("rd_tag", 32'(head.tag), 32'(rd_tag));
			end
		end
		// a rise of not_empty is always the push of the last accepted divide
		if (arst_n && not_empty && !ne_prev) begin
			compare_word("not_empty latency", 32'd20, 32'(edges));
			compare_word("busy", 32'd0, 32'(busy));    // must be down after the push
		end
		ne_prev = not_empty;
		n_left  = exp_q.size();
	end

endmodule

`default_nettype wire

//--- testbench/tb_div_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_div_unit;

	logic        clk;
	logic        arst_n;
	logic        start;
	logic [31:0] dividend;
	logic [31:0] divisor;
	logic        unsign;
	logic [3:0]  tag;
	logic        rd;
	wire         busy;
	wire         not_empty;
	wire  [31:0] rd_quot;
	wire  [31:0] rd_remd;
	wire  [3:0]  rd_tag;

	logic        exp_push;
	logic [31:0] exp_quot;
	logic [31:0] exp_remd;
	logic [3:0]  exp_tag;
	int          value_errs;
	int          other_errs;
	int          exp_left;

	int          n_timeout   = 0;
	int          n_misc      = 0;
	int          outstanding = 0;    // issued and not yet read
	logic [3:0]  next_tag    = 4'd0;

	div_unit i_dut (
		.clk       (clk),
		.arst_n    (arst_n),
		.start     (start),
		.dividend  (dividend),
		.divisor   (divisor),
		.unsign    (unsign),
		.tag       (tag),
		.busy      (busy),
		.rd        (rd),
		.not_empty (not_empty),
		.rd_quot   (rd_quot),
		.rd_remd   (rd_remd),
		.rd_tag    (rd_tag)
	);

	div_checker i_checker (
		.clk        (clk),
		.arst_n     (arst_n),
		.start      (start),
		.busy       (busy),
		.rd         (rd),
		.not_empty  (not_empty),
		.rd_quot    (rd_quot),
		.rd_remd    (rd_remd),
		.rd_tag     (rd_tag),
		.exp_push   (exp_push),
		.exp_quot   (exp_quot),
		.exp_remd   (exp_remd),
		.exp_tag    (exp_tag),
		.value_errs (value_errs),
		.other_errs (other_errs),
		.exp_left   (exp_left)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// quotient truncates toward zero and the remainder follows the dividend as in C
	function automatic logic [63:0] ref_divide(input logic [31:0] a, input logic [31:0] b,
	                                           input logic uns);
		logic [31:0] ma;
		logic [31:0] mb;
		logic [31:0] q;
		logic [31:0] r;
		if (uns) begin
			q = a / b;
			r = a % b;
		end else begin
			ma = a[31] ? -a : a;     // magnitudes, 0x80000000 stays as is
			mb = b[31] ? -b : b;
			q  = ma / mb;
			r  = ma % mb;
			if (a[31] ^ b[31])
				q = -q;
			if (a[31])
				r = -r;
		end
		return {q, r};
	endfunction

	task automatic wait_busy_low(output bit ok);
		int n;
		n = 0;
		while (busy && n < 200) begin
			@(negedge clk);
			n++;
		end
		ok = !busy;
		if (!ok) begin
			$display("timeout: busy stayed high for 200 cycles");
			n_timeout++;
		end
	endtask

	task automatic wait_not_empty(output bit ok);
		int n;
		n = 0;
		while (!not_empty && n < 200) begin
			@(negedge clk);
			n++;
		end
		ok = not_empty;
		if (!ok) begin
			$display("timeout: no result showed up in the queue within 200 cycles");
			n_timeout++;
		end
	endtask

	task automatic issue(input logic [31:0] a, input logic [31:0] b, input logic uns);
		bit          ok;
		logic [63:0] r;
		wait_busy_low(ok);
		if (ok) begin
			r        = ref_divide(a, b, uns);
			dividend = a;
			divisor  = b;
			unsign   = uns;
			tag      = next_tag;
			start    = 1'b1;
			exp_push = 1'b1;
			exp_quot = r[63:32];
			exp_remd = r[31:0];
			exp_tag  = next_tag;
			@(negedge clk);
			start    = 1'b0;
			exp_push = 1'b0;
			next_tag++;
			outstanding++;
		end
	endtask

	task automatic read_one;
		bit ok;
		wait_not_empty(ok);
		if (ok) begin
			rd = 1'b1;
			@(negedge clk);
			rd = 1'b0;
		end
		outstanding--;    // a timed out result counts as gone
	endtask

	task automatic divide_and_read(input logic [31:0] a, input logic [31:0] b, input logic uns);
		issue(a, b, uns);
		read_one;
	endtask

	// ####################################################################
	// stimulus
	// ####################################################################

	initial begin
		int unsigned seed;
		int          i;
		bit          held;
		logic [31:0] a;
		logic [31:0] b;
		logic        uns;
		seed = 32'h0e9b_f582;
		void'($urandom(seed));
		arst_n   = 1'b0;
		start    = 1'b0;
		dividend = '0;
		divisor  = '0;
		unsign   = 1'b0;
		tag      = '0;
		rd       = 1'b0;
		exp_push = 1'b0;
		exp_quot = '0;
		exp_remd = '0;
		exp_tag  = '0;
		repeat (8) @(negedge clk);    // checker looks at reset values meanwhile
		arst_n = 1'b1;
		@(negedge clk);

		// unsigned
		divide_and_read(32'd100, 32'd7, 1'b1);
		divide_and_read(32'd5, 32'd9, 1'b1);            // divisor above dividend
		divide_and_read(32'hffff_ffff, 32'd1, 1'b1);
		divide_and_read(32'hffff_ffff, 32'd3, 1'b1);
		divide_and_read(32'hffff_ffff, 32'hffff_fffe, 1'b1);
		divide_and_read(32'd0, 32'd5, 1'b1);

		// signed, all four sign pairs
		divide_and_read(32'd100, 32'd7, 1'b0);
		divide_and_read(-32'd100, 32'd7, 1'b0);
		divide_and_read(32'd100, -32'd7, 1'b0);
		divide_and_read(-32'd100, -32'd7, 1'b0);
		divide_and_read(-32'd21, 32'd7, 1'b0);          // exact, remainder zero
		divide_and_read(-32'd21, -32'd7, 1'b0);
		divide_and_read(32'h8000_0000, 32'd2, 1'b0);
		divide_and_read(32'h7fff_ffff, -32'd1, 1'b0);

		// back-pressure, four results fill the queue
		for (i = 0; i < 4; i++)
			issue(32'h1000_0000 + 32'(i * 977), 32'd13 + 32'(i), 1'(i));
		held = 1'b1;
		for (i = 0; i < 40; i++) begin
			@(negedge clk);
			if (!busy)
				held = 1'b0;
		end
		if (!held) begin
			$display("busy dropped while the result queue was full");
			n_misc++;
		end
		read_one;
		issue(-32'd5000, 32'd33, 1'b0);                 // fifth goes in after the read
		while (outstanding > 0)
			read_one;

		// random operands with interleaved reads
		for (i = 0; i < 200; i++) begin
			if (outstanding == 4 || (outstanding > 0 && $urandom % 2 == 1))
				read_one;
			a   = $urandom;
			b   = $urandom >> ($urandom % 32);    // spread of divisor sizes
			uns = 1'($urandom);
			while (b == 0 || (!uns && a == 32'h8000_0000 && b == 32'hffff_ffff))
				b = $urandom;
			issue(a, b, uns);
		end
		while (outstanding > 0)
			read_one;

		repeat (3) @(negedge clk);
		@(posedge clk);
		if (exp_left != 0) begin
			$display("%0d issued results were never read back", exp_left);
			n_misc++;
		end
		$display("errors: value %0d, checker %0d, timeout %0d, other %0d",
		         value_errs, other_errs, n_timeout, n_misc);
		if (value_errs + other_errs + n_timeout + n_misc == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
rtl/div_pkg.sv
rtl/div_result_if.sv
rtl/csa35.sv
rtl/long_div.sv
rtl/div_sequencer.sv
rtl/result_fifo.sv
rtl/div_unit.sv
testbench/div_checker.sv
testbench/tb_div_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the divide unit testbench with Verilator, run it and check the log

set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -j 0 \
	--top-module tb_div_unit \
	-Mdir obj_dir -o sim_div \
	-f compile.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_div > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Testbench passed" "$log"; then
	exit 0
fi
echo "pass message not found in $log"
exit 1
